/* hdl/analog_pkg.sv */
// shared widths, register map and bus/datapath types for the analog path
// single adc_clk domain; all samples are 14 bit two's complement
// ADC and DAC codes use the negative-slope format of the converters

package analog_pkg;

  //////////////////////////////////////////////////
  // widths

  localparam int ADC_IN_W   = 16;  // raw ADC lane, low 2 bits reserved
  localparam int SAMPLE_W   = 14;  // signed sample
  localparam int NUM_CH     = 2;
  localparam int GAIN_W     = 16;  // signed gain
  localparam int GAIN_SHIFT = 12;  // 4096 is unity gain
  localparam int PROD_W     = SAMPLE_W + GAIN_W;  // full product
  localparam int SUM_W      = SAMPLE_W + 1;       // offset + feedback
  localparam int SYS_AW     = 20;
  localparam int SYS_DW     = 32;

  // DAC code for a zero sample
  localparam logic [SAMPLE_W-1:0] DAC_ZERO_CODE = 14'h1FFF;

  //////////////////////////////////////////////////
  // register map

  localparam logic [SYS_AW-1:0] REG_CTRL     = 20'h00;  // bit 0 digital_loop
  localparam logic [SYS_AW-1:0] REG_OFFSET_A = 20'h10;
  localparam logic [SYS_AW-1:0] REG_OFFSET_B = 20'h14;
  localparam logic [SYS_AW-1:0] REG_GAIN_A   = 20'h20;
  localparam logic [SYS_AW-1:0] REG_GAIN_B   = 20'h24;

  //////////////////////////////////////////////////
  // types

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [GAIN_W-1:0]   gain_t;

  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } sample_pair_t;

  typedef struct packed {
    gain_t ch_a;
    gain_t ch_b;
  } gain_pair_t;

  typedef struct packed {
    logic         digital_loop;  // DAC sum replaces ADC samples
    sample_pair_t offset;        // generator value per channel
    gain_pair_t   gain;          // proportional feedback gain
  } analog_cfg_t;  // 61 bits

  typedef struct packed {
    logic [SYS_AW-1:0] addr;
    logic [SYS_DW-1:0] wdata;
    logic              wen;   // one cycle strobe
    logic              ren;   // one cycle strobe
  } sys_req_t;

  typedef struct packed {
    logic [SYS_DW-1:0] rdata;
    logic              ack;
    logic              err;   // unmapped address
  } sys_rsp_t;

  // negative slope <-> two's complement, same bit flip both ways
  function automatic logic [SAMPLE_W-1:0] flip_code(input logic [SAMPLE_W-1:0] code);
    return {code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]};
  endfunction

endpackage

/* hdl/analog_regs.sv */
// register bank on the system bus, exact address match only
// every wen/ren strobe gets ack one cycle later, err on unmapped address
// writes land on the ack cycle; unmapped reads return zero

`timescale 1ns/1ps

module analog_regs (
  input  logic                   adc_clk,
  input  logic                   rst_n_i,    // sync, active low
  input  analog_pkg::sys_req_t    sys_req_i,
  output analog_pkg::sys_rsp_t    sys_rsp_o,
  output analog_pkg::analog_cfg_t cfg_o
);

//////////////////////////////////////////////////
// local signals

analog_pkg::analog_cfg_t cfg_q;
analog_pkg::sys_rsp_t    rsp_q;

logic                          strobe;   // any access this cycle
logic                          addr_hit; // address maps to a register
logic [analog_pkg::SYS_DW-1:0] rd_mux;

assign strobe = sys_req_i.wen | sys_req_i.ren;

//////////////////////////////////////////////////
// address decode and read mux

always_comb
begin
  addr_hit = 1'b1;
  rd_mux   = '0;
  case (sys_req_i.addr)
    analog_pkg::REG_CTRL:
      rd_mux = {{(analog_pkg::SYS_DW-1){1'b0}}, cfg_q.digital_loop};
    analog_pkg::REG_OFFSET_A:
      rd_mux = {{(analog_pkg::SYS_DW-analog_pkg::SAMPLE_W){1'b0}}, cfg_q.offset.ch_a};
    analog_pkg::REG_OFFSET_B:
      rd_mux = {{(analog_pkg::SYS_DW-analog_pkg::SAMPLE_W){1'b0}}, cfg_q.offset.ch_b};
    analog_pkg::REG_GAIN_A:
      rd_mux = {{(analog_pkg::SYS_DW-analog_pkg::GAIN_W){1'b0}}, cfg_q.gain.ch_a};
    analog_pkg::REG_GAIN_B:
      rd_mux = {{(analog_pkg::SYS_DW-analog_pkg::GAIN_W){1'b0}}, cfg_q.gain.ch_b};
    default:
      addr_hit = 1'b0;  // rd_mux stays zero
  endcase
end

//////////////////////////////////////////////////
// configuration registers

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    cfg_q <= '0;  // loop off, offsets and gains zero
  end
  else if (sys_req_i.wen && addr_hit)
  begin
    case (sys_req_i.addr)
      analog_pkg::REG_CTRL:     cfg_q.digital_loop <= sys_req_i.wdata[0];
      analog_pkg::REG_OFFSET_A: cfg_q.offset.ch_a  <= sys_req_i.wdata[analog_pkg::SAMPLE_W-1:0];
      analog_pkg::REG_OFFSET_B: cfg_q.offset.ch_b  <= sys_req_i.wdata[analog_pkg::SAMPLE_W-1:0];
      analog_pkg::REG_GAIN_A:   cfg_q.gain.ch_a    <= sys_req_i.wdata[analog_pkg::GAIN_W-1:0];
      analog_pkg::REG_GAIN_B:   cfg_q.gain.ch_b    <= sys_req_i.wdata[analog_pkg::GAIN_W-1:0];
      default:                  cfg_q              <= cfg_q;
    endcase
  end
end

//////////////////////////////////////////////////
// bus response, one cycle after the strobe

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    rsp_q <= '0;
  end
  else
  begin
    rsp_q.ack <= strobe;
    rsp_q.err <= strobe & ~addr_hit;
    // read data only on a read, zero otherwise
    if (sys_req_i.ren)
    begin
      rsp_q.rdata <= rd_mux;
    end
    else
    begin
      rsp_q.rdata <= '0;
    end
  end
end

assign sys_rsp_o = rsp_q;
assign cfg_o     = cfg_q;

endmodule

/* hdl/adc_frontend.sv */
// ADC capture, lane 0 is channel a and lane 1 is channel b
// one register stage on the raw lanes, conversion and loop mux after it
// loop_i must come from a registered path, else a combinational loop forms

`timescale 1ns/1ps

module adc_frontend (
  input  logic                                                adc_clk,
  input  logic                                                rst_n_i,
  input  logic [analog_pkg::NUM_CH-1:0][analog_pkg::ADC_IN_W-1:0] adc_dat_i,
  input  analog_pkg::sample_pair_t                            loop_i,  // DAC sum
  input  analog_pkg::analog_cfg_t                             cfg_i,
  output analog_pkg::sample_pair_t                            sample_o
);

//////////////////////////////////////////////////
// input registers

logic [analog_pkg::NUM_CH-1:0][analog_pkg::SAMPLE_W-1:0] raw_q;  // neg-slope codes
analog_pkg::sample_pair_t                                adc_conv;

// keep top 14 bits, reserved low bits dropped
always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    raw_q <= '0;
  end
  else
  begin
    for (int ch = 0; ch < analog_pkg::NUM_CH; ch++)
    begin
      raw_q[ch] <= adc_dat_i[ch][analog_pkg::ADC_IN_W-1 -: analog_pkg::SAMPLE_W];
    end
  end
end

//////////////////////////////////////////////////
// neg-slope to two's complement

// sign bit kept, magnitude bits inverted
assign adc_conv.ch_a = analog_pkg::flip_code(raw_q[0]);
assign adc_conv.ch_b = analog_pkg::flip_code(raw_q[1]);

// digital loopback replaces both channels at once
assign sample_o = cfg_i.digital_loop ? loop_i : adc_conv;

endmodule

/* hdl/proportional_feedback.sv */
// per-channel proportional feedback, fb = sat14((sample * gain) >>> 12)
// gain is signed Q3.12, so 4096 passes the sample unchanged
// one register stage, result clears to zero on reset

`timescale 1ns/1ps

module proportional_feedback (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  analog_pkg::sample_pair_t  sample_i,
  input  analog_pkg::analog_cfg_t   cfg_i,
  output analog_pkg::sample_pair_t  fb_o
);

//////////////////////////////////////////////////
// multiply, shift and saturate

// full precision product, arithmetic shift keeps the sign
function automatic analog_pkg::sample_t scale_sat(
  input analog_pkg::sample_t s,
  input analog_pkg::gain_t   g
);
  logic signed [analog_pkg::PROD_W-1:0] prod;
  logic signed [analog_pkg::PROD_W-1:0] shifted;
  logic                                 sgn;
  prod    = s * g;  // both signed, 30 bit context
  shifted = prod >>> analog_pkg::GAIN_SHIFT;
  sgn     = shifted[analog_pkg::PROD_W-1];
  // fits when all bits above the sample msb match the sign
  if (shifted[analog_pkg::PROD_W-1:analog_pkg::SAMPLE_W-1] ==
      {(analog_pkg::PROD_W-analog_pkg::SAMPLE_W+1){sgn}})
  begin
    return shifted[analog_pkg::SAMPLE_W-1:0];
  end
  else
  begin
    return {sgn, {(analog_pkg::SAMPLE_W-1){~sgn}}};  // clip to 0x1FFF or 0x2000
  end
endfunction

analog_pkg::sample_pair_t fb_next;
analog_pkg::sample_pair_t fb_q;

assign fb_next.ch_a = scale_sat(sample_i.ch_a, cfg_i.gain.ch_a);
assign fb_next.ch_b = scale_sat(sample_i.ch_b, cfg_i.gain.ch_b);

//////////////////////////////////////////////////
// output register

// this register also breaks the loopback path
always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    fb_q <= '0;
  end
  else
  begin
    fb_q <= fb_next;
  end
end

assign fb_o = fb_q;

endmodule

/* hdl/dac_output_stage.sv */
// DAC output, offset + feedback saturated to 14 bits per channel
// sum_o is combinational, used as loopback source
// DAC words are registered neg-slope codes, 14'h1FFF in reset

`timescale 1ns/1ps

module dac_output_stage (
  input  logic                              adc_clk,
  input  logic                              rst_n_i,
  input  analog_pkg::sample_pair_t           fb_i,
  input  analog_pkg::analog_cfg_t            cfg_i,
  output analog_pkg::sample_pair_t           sum_o,
  output logic [analog_pkg::SAMPLE_W-1:0]    dac_dat_a_o,
  output logic [analog_pkg::SAMPLE_W-1:0]    dac_dat_b_o
);

//////////////////////////////////////////////////
// sum and saturation

// 15 bit sum, top two bits differ on overflow
function automatic analog_pkg::sample_t sat_sum(
  input analog_pkg::sample_t offset,
  input analog_pkg::sample_t fb
);
  logic signed [analog_pkg::SUM_W-1:0] sum;
  logic                                sgn;
  sum = offset + fb;  // sign extended to 15 bits
  sgn = sum[analog_pkg::SUM_W-1];
  if (sgn ^ sum[analog_pkg::SUM_W-2])
  begin
    return {sgn, {(analog_pkg::SAMPLE_W-1){~sgn}}};  // clip
  end
  else
  begin
    return sum[analog_pkg::SAMPLE_W-1:0];
  end
endfunction

// generator offset plus feedback, per channel
assign sum_o.ch_a = sat_sum(cfg_i.offset.ch_a, fb_i.ch_a);
assign sum_o.ch_b = sat_sum(cfg_i.offset.ch_b, fb_i.ch_b);

//////////////////////////////////////////////////
// output registers

// two's complement back to neg-slope DAC code
always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    dac_dat_a_o <= analog_pkg::DAC_ZERO_CODE;  // code of 0
    dac_dat_b_o <= analog_pkg::DAC_ZERO_CODE;
  end
  else
  begin
    dac_dat_a_o <= analog_pkg::flip_code(sum_o.ch_a);
    dac_dat_b_o <= analog_pkg::flip_code(sum_o.ch_b);
  end
end

endmodule

/* hdl/analog_top.sv */
// analog signal path top, single adc_clk domain
// adc_dat_i to dac_dat_*_o latency is 3 cycles with loopback off
// DAC channels leave as two separate registered words

`timescale 1ns/1ps

module analog_top (
  input  logic                                                adc_clk,
  input  logic                                                rst_n_i,  // sync, active low
  input  logic [analog_pkg::NUM_CH-1:0][analog_pkg::ADC_IN_W-1:0] adc_dat_i,
  input  analog_pkg::sys_req_t                                sys_req_i,
  output analog_pkg::sys_rsp_t                                sys_rsp_o,
  output logic [analog_pkg::SAMPLE_W-1:0]                     dac_dat_a_o,
  output logic [analog_pkg::SAMPLE_W-1:0]                     dac_dat_b_o
);

//////////////////////////////////////////////////
// local signals

analog_pkg::analog_cfg_t  cfg;      // register bank to datapath
analog_pkg::sample_pair_t adc_smp;  // converted or looped samples
analog_pkg::sample_pair_t fb;       // registered feedback
analog_pkg::sample_pair_t dac_sum;  // saturated sum, loop source

//////////////////////////////////////////////////
// control

analog_regs i_regs (
  .adc_clk   (adc_clk  ),
  .rst_n_i   (rst_n_i  ),
  .sys_req_i (sys_req_i),
  .sys_rsp_o (sys_rsp_o),
  .cfg_o     (cfg      )
);

//////////////////////////////////////////////////
// datapath

adc_frontend i_adc (
  .adc_clk   (adc_clk  ),
  .rst_n_i   (rst_n_i  ),
  .adc_dat_i (adc_dat_i),
  .loop_i    (dac_sum  ),  // digital loopback
  .cfg_i     (cfg      ),
  .sample_o  (adc_smp  )
);

proportional_feedback i_fb (
  .adc_clk  (adc_clk),
  .rst_n_i  (rst_n_i),
  .sample_i (adc_smp),
  .cfg_i    (cfg    ),
  .fb_o     (fb     )
);

dac_output_stage i_dac (
  .adc_clk     (adc_clk    ),
  .rst_n_i     (rst_n_i    ),
  .fb_i        (fb         ),
  .cfg_i       (cfg        ),
  .sum_o       (dac_sum    ),
  .dac_dat_a_o (dac_dat_a_o),
  .dac_dat_b_o (dac_dat_b_o)
);

endmodule

/* verification/analog_checker.sv */
// bus response and DAC reset assertions, bound into the register bank and DAC stage
// BUS_SIDE picks the bus checks or the DAC reset check for each bound copy

`timescale 1ns/1ps

module analog_checker #(
  parameter bit BUS_SIDE = 1'b1  // 1: bus response, 0: DAC reset state
) (
  input logic        adc_clk,
  input logic        rst_n_i,
  input logic        strobe_i,  // wen or ren
  input logic        ack_i,
  input logic        err_i,
  input logic [31:0] rdata_i,
  input logic [13:0] dac_a_i,
  input logic [13:0] dac_b_i
);

int fail_count = 0;  // assertion failures so far

if (BUS_SIDE)
begin : g_bus

  //////////////////////////////////////////////////
  // bus response

  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    strobe_i |=> ack_i)
    else
    begin
      fail_count = fail_count + 1;
      $error("ack missing one cycle after a bus strobe");
    end

  no_ack_without_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !strobe_i |=> !ack_i)
    else
    begin
      fail_count = fail_count + 1;
      $error("ack without a strobe one cycle before");
    end

  // err only rides on an ack, data stays zero
  err_with_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    err_i |-> (ack_i && rdata_i == 32'h0))
    else
    begin
      fail_count = fail_count + 1;
      $error("err seen without ack or with nonzero read data");
    end

end
else
begin : g_dac

  //////////////////////////////////////////////////
  // DAC reset state

  dac_zero_in_reset: assert property (@(posedge adc_clk)
    !rst_n_i |=> (dac_a_i == 14'h1FFF && dac_b_i == 14'h1FFF))
    else
    begin
      fail_count = fail_count + 1;
      $error("DAC words not at the zero code during reset");
    end

end

endmodule

bind analog_regs analog_checker #(.BUS_SIDE(1'b1)) bus_chk (
  .adc_clk  (adc_clk                      ),
  .rst_n_i  (rst_n_i                      ),
  .strobe_i (sys_req_i.wen | sys_req_i.ren),
  .ack_i    (sys_rsp_o.ack                ),
  .err_i    (sys_rsp_o.err                ),
  .rdata_i  (sys_rsp_o.rdata              ),
  .dac_a_i  (14'h0                        ),
  .dac_b_i  (14'h0                        )
);

bind dac_output_stage analog_checker #(.BUS_SIDE(1'b0)) dac_chk (
  .adc_clk  (adc_clk    ),
  .rst_n_i  (rst_n_i    ),
  .strobe_i (1'b0       ),
  .ack_i    (1'b0       ),
  .err_i    (1'b0       ),
  .rdata_i  (32'h0      ),
  .dac_a_i  (dac_dat_a_o),
  .dac_b_i  (dac_dat_b_o)
);

/* verification/analog_tb.sv */
// testbench for the analog path, inputs change 2 ns after the rising edge
// DAC words are checked at the falling edge against a cycle model of both channels
// the model follows a shadow of the register bank, updated when a write is acked

`timescale 1ns/1ps

module analog_tb;

localparam int ACK_TIMEOUT = 8;  // cycles

typedef struct packed {
  logic [13:0]        raw;  // captured neg-slope code
  logic signed [13:0] fb;   // gain stage register
  logic [13:0]        dac;  // output code
} chan_model_t;

logic                    adc_clk = 1'b0;
logic                    rst_n   = 1'b0;
logic [1:0][15:0]        adc_dat = '0;  // lane 0 is channel a
analog_pkg::sys_req_t    sys_req = '0;
analog_pkg::sys_rsp_t    sys_rsp;
logic [13:0]             dac_a;
logic [13:0]             dac_b;
analog_pkg::analog_cfg_t cfg_shadow = '0;
chan_model_t             model_a = '{raw: 14'h0, fb: 14'sh0, dac: 14'h1FFF};
chan_model_t             model_b = '{raw: 14'h0, fb: 14'sh0, dac: 14'h1FFF};
logic [31:0]             lfsr = 32'h77ee1e56;
int                      errors = 0;
int                      checks = 0;
bit                      full_scale = 1'b0;  // ADC swings between the end codes
bit                      seen_hi = 1'b0;     // code of 0x1FFF seen
bit                      seen_lo = 1'b0;     // code of 0x2000 seen

analog_top dut_i (
  .adc_clk     (adc_clk),
  .rst_n_i     (rst_n  ),
  .adc_dat_i   (adc_dat),
  .sys_req_i   (sys_req),
  .sys_rsp_o   (sys_rsp),
  .dac_dat_a_o (dac_a  ),
  .dac_dat_b_o (dac_b  )
);

initial
begin
  forever #20 adc_clk = ~adc_clk;  // 40 ns
end

initial
begin
  #200_000;
  $display("simulation ran past its time limit, a wait never ended");
  $display("Test failed");
  $finish;
end

//////////////////////////////////////////////////
// random data and reference model

// Fibonacci, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic random_bits(input int n, output logic [15:0] w);
  w = '0;
  for (int i = 0; i < n; i++)
  begin
    lfsr = lfsr_step(lfsr);  // one step per bit
    w[i] = lfsr[0];
  end
endtask

function automatic int clamp14(input int v);
  if (v > 8191) return 8191;
  if (v < -8192) return -8192;
  return v;
endfunction

// one clock of one channel
function automatic chan_model_t ref_next(input chan_model_t st, input logic [15:0] adc,
                                         input logic loop, input logic signed [13:0] offset,
                                         input logic signed [15:0] gain, input logic rst);
  chan_model_t nx;
  int          smp;
  int          sum;
  sum = clamp14(int'(offset) + int'(st.fb));        // saturated output sum
  smp = int'($signed(st.raw ^ 14'h1FFF));           // sign kept, rest inverted
  if (loop)
  begin
    smp = sum;  // sum feeds the gain stage
  end
  nx.raw = adc[15:2];
  nx.fb  = 14'(clamp14((smp * int'(gain)) >>> 12));
  nx.dac = 14'(sum) ^ 14'h1FFF;
  if (!rst)
  begin
    nx = '{raw: 14'h0, fb: 14'sh0, dac: 14'h1FFF};
  end
  return nx;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("MISMATCH t=%0t %s got=%h expected=%h", $time, name, got, exp);
  end
endtask

// outputs settled here, model then steps to the next edge
always @(negedge adc_clk)
begin
  check_value("dac_dat_a_o", 32'(dac_a), 32'(model_a.dac));
  check_value("dac_dat_b_o", 32'(dac_b), 32'(model_b.dac));
  if (dac_a == 14'h0000 || dac_b == 14'h0000) seen_hi = 1'b1;
  if (dac_a == 14'h3FFF || dac_b == 14'h3FFF) seen_lo = 1'b1;
  model_a = ref_next(model_a, adc_dat[0], cfg_shadow.digital_loop, cfg_shadow.offset.ch_a,
                     cfg_shadow.gain.ch_a, rst_n);
  model_b = ref_next(model_b, adc_dat[1], cfg_shadow.digital_loop, cfg_shadow.offset.ch_b,
                     cfg_shadow.gain.ch_b, rst_n);
end

//////////////////////////////////////////////////
// bus and stimulus tasks

task automatic bus_access(input logic wr, input logic [19:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
  int waited;
  @(posedge adc_clk);
  #2;
  sys_req.addr  = addr;
  sys_req.wdata = wdata;
  sys_req.wen   = wr;
  sys_req.ren   = ~wr;
  @(posedge adc_clk);
  #2;
  sys_req.wen = 1'b0;  // strobe lasts one cycle
  sys_req.ren = 1'b0;
  waited = 0;
  while (!sys_rsp.ack && waited < ACK_TIMEOUT)
  begin
    @(posedge adc_clk);
    #2;
    waited++;
  end
  rdata = sys_rsp.rdata;
  err   = sys_rsp.err;
  if (!sys_rsp.ack)
  begin
    errors++;
    $display("no bus ack for address %h within %0d cycles", addr, ACK_TIMEOUT);
  end
endtask

task automatic bus_write(input logic [19:0] addr, input logic [31:0] wdata);
  logic [31:0] rd;
  logic        err;
  bus_access(1'b1, addr, wdata, rd, err);
  check_value("sys_rsp_o.err", 32'(err), 32'h0);
  case (addr)  // register took the value on the ack edge
    analog_pkg::REG_CTRL:     cfg_shadow.digital_loop = wdata[0];
    analog_pkg::REG_OFFSET_A: cfg_shadow.offset.ch_a  = wdata[13:0];
    analog_pkg::REG_OFFSET_B: cfg_shadow.offset.ch_b  = wdata[13:0];
    analog_pkg::REG_GAIN_A:   cfg_shadow.gain.ch_a    = wdata[15:0];
    analog_pkg::REG_GAIN_B:   cfg_shadow.gain.ch_b    = wdata[15:0];
    default:                  cfg_shadow              = cfg_shadow;
  endcase
endtask

task automatic read_expect(input logic [19:0] addr, input logic [31:0] exp);
  logic [31:0] rd;
  logic        err;
  bus_access(1'b0, addr, 32'h0, rd, err);
  check_value("sys_rsp_o.err", 32'(err), 32'h0);
  check_value("sys_rsp_o.rdata", rd, exp);
endtask

task automatic setup(input logic loop, input logic [31:0] off_a, input logic [31:0] off_b,
                     input logic [31:0] gain_a, input logic [31:0] gain_b);
  bus_write(analog_pkg::REG_CTRL, 32'(loop));
  bus_write(analog_pkg::REG_OFFSET_A, off_a);
  bus_write(analog_pkg::REG_OFFSET_B, off_b);
  bus_write(analog_pkg::REG_GAIN_A, gain_a);
  bus_write(analog_pkg::REG_GAIN_B, gain_b);
endtask

task automatic run_cycles(input int n);
  logic [15:0] w;
  for (int i = 0; i < n; i++)
  begin
    @(posedge adc_clk);
    #2;
    for (int ch = 0; ch < 2; ch++)
    begin
      if (full_scale)
      begin
        random_bits(1, w);
        w = w[0] ? 16'hFFFC : 16'h0000;  // most negative or most positive
      end
      else
      begin
        random_bits(16, w);
      end
      adc_dat[ch] = w;
    end
  end
endtask

task automatic report_test(input string name, input int errors_before);
  $display("%-24s %s, %0d errors", name, (errors == errors_before) ? "ok" : "FAILED",
           errors - errors_before);
endtask

//////////////////////////////////////////////////
// test sequence

initial
begin
  static logic [19:0] addr [5] = '{20'h00, 20'h10, 20'h14, 20'h20, 20'h24};
  static logic [31:0] wval [5] = '{32'hFFFF_FFFF, 32'hFFFF_ABCD, 32'h1234_5678,
                                   32'h1234_8765, 32'hFFFF_0FF1};
  static logic [31:0] rval [5] = '{32'h1, 32'h2BCD, 32'h1678, 32'h8765, 32'h0FF1};
  logic [31:0] rd;
  logic        err;
  int          mark;
  int          asrt;
  for (int i = 0; i < 8; i++)
  begin
    @(posedge adc_clk);
  end
  #2;
  rst_n = 1'b1;

  mark = errors;
  for (int i = 0; i < 5; i++) read_expect(addr[i], 32'h0);  // reset values
  for (int i = 0; i < 5; i++)
  begin
    bus_write(addr[i], wval[i]);
    read_expect(addr[i], rval[i]);
  end
  bus_access(1'b0, 20'h30, 32'h0, rd, err);
  check_value("sys_rsp_o.err", 32'(err), 32'h1);
  check_value("sys_rsp_o.rdata", rd, 32'h0);
  bus_access(1'b1, 20'h44, 32'hFFFF_FFFF, rd, err);
  check_value("sys_rsp_o.err", 32'(err), 32'h1);
  report_test("register access", mark);

  mark = errors;
  setup(1'b0, 32'h0, 32'h0, 32'h1000, 32'h1000);  // unity gain
  run_cycles(200);
  report_test("unity pass-through", mark);

  mark = errors;
  setup(1'b0, 32'h1234, 32'h32FB, 32'h0, 32'h0);  // b is -3333
  run_cycles(100);
  check_value("dac_dat_a_o", 32'(dac_a), 32'(14'h1234 ^ 14'h1FFF));
  check_value("dac_dat_b_o", 32'(dac_b), 32'(14'h32FB ^ 14'h1FFF));
  report_test("offset only", mark);

  mark = errors;
  setup(1'b0, 32'h1800, 32'h2800, 32'h7FFF, 32'h7FFF);  // +-6144, gain near 8
  full_scale = 1'b1;
  seen_hi    = 1'b0;
  seen_lo    = 1'b0;
  run_cycles(100);
  full_scale = 1'b0;
  if (!(seen_hi && seen_lo))
  begin
    errors++;
    $display("saturation codes never reached on the DAC outputs");
  end
  report_test("saturation", mark);

  mark = errors;
  setup(1'b1, 32'd1000, 32'h3448, 32'hF800, 32'h0C00);  // b: -3000, gain 0.75
  run_cycles(300);
  check_value("dac_dat_b_o", 32'(dac_b), 32'h3FFF);  // settles at -8192
  report_test("digital loopback", mark);

  asrt = dut_i.i_regs.bus_chk.fail_count + dut_i.i_dac.dac_chk.fail_count;
  if (asrt != 0)
  begin
    errors += asrt;
    $display("%0d assertion failures in the bound checkers", asrt);
  end
  $display("summary: %0d checks, %0d errors", checks, errors);
  if (errors == 0)
  begin
    $display("Test passed");
  end
  else
  begin
    $display("Test failed");
  end
  $finish;
end

endmodule

/* all.f */
hdl/analog_pkg.sv
hdl/analog_regs.sv
hdl/adc_frontend.sv
hdl/proportional_feedback.sv
hdl/dac_output_stage.sv
hdl/analog_top.sv
verification/analog_checker.sv
verification/analog_tb.sv

/* run.sh */
#!/bin/sh
# build the analog path testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module analog_tb -f all.f -o analog_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/analog_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
